// File: flist.f
mbox_pkg.sv
fifo_ctrl_fsm.sv
mbox_queue.sv
buf_arbiter.sv
buf_ram.sv
axil_mbox_slave.sv
mbox_top.sv
tb_mbox.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mailbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --assert --timescale 1ns/1ps -j 0 \
        --top-module tb_mbox -Mdir "$BUILD_DIR" -o sim_mbox -f flist.f; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_mbox" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
exit 1

// File: tb_mbox.sv
`timescale 1ns/1ps
module tb_mbox;
    import mbox_pkg::*;

    localparam int DEPTH = 16;
    localparam int CLK_PERIOD = 4;
    // Generous cycle budget per table entry with its status read
    localparam int OP_CYCLES = 40;

    typedef struct packed {
        logic        is_read;
        logic        stall;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [1:0]  exp_resp;
        logic [31:0] exp_data;
        logic [31:0] exp_stat;
    } op_t;

    logic     wr_clk;
    logic     rd_srst;
    axil_aw_t aw;
    axil_w_t  w;
    logic     bready;
    axil_ar_t ar;
    logic     rready;
    logic     awready;
    logic     wready;
    axil_b_t  b;
    logic     arready;
    axil_r_t  r;

    op_t         ops[$];
    logic [31:0] model_hi[$];
    logic [31:0] model_lo[$];
    integer      seed = 32'h3241_760c;
    // Response, data, status and protocol errors
    int          err_cnt[4];
    int          cur_op;
    string       where_str;
    bit          table_ready;

    mbox_top #(
        .DEPTH       (DEPTH),
        .WR_OPT_MODE (OPT_MODE_TIMING),
        .RD_OPT_MODE (OPT_MODE_TIMING)
    ) i_dut (
        .wr_clk  (wr_clk),
        .rd_srst (rd_srst),
        .aw      (aw),
        .w       (w),
        .bready  (bready),
        .ar      (ar),
        .rready  (rready),
        .awready (awready),
        .wready  (wready),
        .b       (b),
        .arready (arready),
        .r       (r)
    );

    initial begin
        wr_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and stimulus table
    // ------------------------------------------------------------------------
    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s = '0;
        s[4:0] = 5'(model_hi.size());
        s[12:8] = 5'(model_lo.size());
        s[16] = (model_hi.size() == 0);
        s[17] = (model_hi.size() == DEPTH);
        s[18] = (model_lo.size() == 0);
        s[19] = (model_lo.size() == DEPTH);
        return s;
    endfunction

    task automatic add_op(input logic is_read, input logic [3:0] addr,
                          input logic [31:0] data, input logic stall);
        op_t op;
        op.is_read = is_read;
        op.stall = stall;
        op.addr = addr;
        op.data = data;
        op.exp_resp = RESP_OKAY;
        op.exp_data = '0;
        if (!is_read) begin
            if (addr == ADDR_HI && model_hi.size() < DEPTH) begin
                model_hi.push_back(data);
            end else if (addr == ADDR_LO && model_lo.size() < DEPTH) begin
                model_lo.push_back(data);
            end else begin
                op.exp_resp = RESP_SLVERR;
            end
        end else if (addr == ADDR_HI && model_hi.size() > 0) begin
            op.exp_data = model_hi.pop_front();
        end else if (addr == ADDR_LO && model_lo.size() > 0) begin
            op.exp_data = model_lo.pop_front();
        end else if (addr == ADDR_STAT) begin
            op.exp_data = model_status();
        end else begin
            // Empty queue or unmapped address
            op.exp_resp = RESP_SLVERR;
        end
        op.exp_stat = model_status();
        ops.push_back(op);
    endtask

    task automatic build_table();
        logic [31:0] sel;
        logic [31:0] data;
        // Pops from empty queues
        add_op(1'b1, ADDR_HI, 32'h0, 1'b0);
        add_op(1'b1, ADDR_LO, 32'h0, 1'b0);
        add_op(1'b1, ADDR_STAT, 32'h0, 1'b0);
        // Order within a queue and no mixing between queues
        for (int k = 0; k < 3; k++) begin
            add_op(1'b0, ADDR_HI, 32'h1000_0000 + k, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            add_op(1'b0, ADDR_LO, 32'h2000_0000 + k, 1'b0);
        end
        add_op(1'b1, ADDR_LO, 32'h0, 1'b0);
        for (int k = 0; k < 3; k++) begin
            add_op(1'b1, ADDR_HI, 32'h0, 1'b0);
        end
        add_op(1'b1, ADDR_LO, 32'h0, 1'b0);
        // Fill the high queue, then one push too many
        for (int k = 0; k < DEPTH; k++) begin
            add_op(1'b0, ADDR_HI, 32'hA500_0000 + (k << 8) + k, 1'b0);
        end
        add_op(1'b0, ADDR_HI, 32'hDEAD_BEEF, 1'b0);
        for (int k = 0; k < 4; k++) begin
            add_op(1'b0, ADDR_LO, 32'h5A00_0000 + k, 1'b0);
        end
        for (int k = 0; k <= DEPTH; k++) begin
            add_op(1'b1, ADDR_HI, 32'h0, k[0]);
        end
        // Status write and unmapped address
        add_op(1'b0, ADDR_STAT, 32'h1234_5678, 1'b0);
        add_op(1'b0, 4'hC, 32'h8765_4321, 1'b0);
        add_op(1'b1, 4'hC, 32'h0, 1'b0);
        // Random mix over both queues with pushes a bit more likely
        for (int k = 0; k < 48; k++) begin
            sel = $random(seed);
            data = $random(seed);
            add_op(sel[2:0] > 3'd4, sel[3] ? ADDR_LO : ADDR_HI, data, 1'b1);
        end
        while (model_hi.size() > 0) begin
            add_op(1'b1, ADDR_HI, 32'h0, 1'b1);
        end
        while (model_lo.size() > 0) begin
            add_op(1'b1, ADDR_LO, 32'h0, 1'b1);
        end
        add_op(1'b1, ADDR_HI, 32'h0, 1'b0);
        add_op(1'b1, ADDR_LO, 32'h0, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Bus transactions that start on a rising edge
    // ------------------------------------------------------------------------
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              output logic [1:0] resp, output int lat);
        bit seen;
        bit hit;
        aw <= '{addr: addr, valid: 1'b1};
        w <= '{data: data, valid: 1'b1};
        do begin
            @(posedge wr_clk);
        end while (!(awready && wready));
        aw.valid <= 1'b0;
        w.valid <= 1'b0;
        lat = 0;
        seen = 1'b0;
        do begin
            @(posedge wr_clk);
            if (!seen) begin
                lat++;
            end
            seen = seen || b.valid;
            hit = b.valid && bready;
        end while (!hit);
        resp = b.resp;
    endtask

    task automatic axil_read(input logic [3:0] addr, input logic stall,
                             output logic [31:0] data, output logic [1:0] resp,
                             output int lat);
        bit seen;
        bit hit;
        ar <= '{addr: addr, valid: 1'b1};
        do begin
            @(posedge wr_clk);
        end while (!arready);
        ar.valid <= 1'b0;
        if (stall) begin
            rready <= 1'b0;
        end
        lat = 0;
        seen = 1'b0;
        do begin
            @(posedge wr_clk);
            if (!seen) begin
                lat++;
            end
            seen = seen || r.valid;
            hit = r.valid && rready;
            if (r.valid && !rready) begin
                // A waiting read response keeps the AR channel closed
                check_field(3, "arready", 32'(arready), 32'h0);
            end
            if (!hit && stall) begin
                // Host ready about three cycles in four
                rready <= (($random(seed) & 3) != 0);
            end
        end while (!hit);
        data = r.data;
        resp = r.resp;
        rready <= 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic check_field(input int cat, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: %s = 0x%0h, expected 0x%0h", where_str, name, got, exp);
            err_cnt[cat]++;
        end
    endtask

    task automatic check_latency(input int lat, input int expect_cyc, input bit exact);
        assert (exact ? (lat == expect_cyc) : (lat >= expect_cyc)) else begin
            $display("%s: response came %0d cycles after the transfer, expected %s%0d",
                     where_str, lat, exact ? "" : "at least ", expect_cyc);
            err_cnt[3]++;
        end
    endtask

    task automatic report_counts();
        $display("Errors: response %0d, data %0d, status %0d, protocol %0d",
                 err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3]);
    endtask

    task automatic run_table();
        op_t         op;
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        int          lat;
        for (int i = 0; i < ops.size(); i++) begin
            cur_op = i;
            op = ops[i];
            where_str = $sformatf("entry %0d", i);
            if (op.is_read) begin
                axil_read(op.addr, op.stall, got_data, got_resp, lat);
                check_field(1, "r.data", got_data, op.exp_data);
                check_field(0, "r.resp", 32'(got_resp), 32'(op.exp_resp));
            end else begin
                axil_write(op.addr, op.data, got_resp, lat);
                check_field(0, "b.resp", 32'(got_resp), 32'(op.exp_resp));
            end
            if (op.exp_resp == RESP_SLVERR || op.addr == ADDR_STAT) begin
                check_latency(lat, 1, 1'b1);
            end else begin
                check_latency(lat, op.is_read ? 3 : 2, 1'b0);
            end
            // Status after every entry
            where_str = $sformatf("status after entry %0d", i);
            axil_read(ADDR_STAT, 1'b0, got_data, got_resp, lat);
            check_field(2, "r.data", got_data, op.exp_stat);
            check_field(0, "r.resp", 32'(got_resp), 32'(RESP_OKAY));
            check_latency(lat, 1, 1'b1);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rd_srst <= 1'b1;
        aw <= '0;
        w <= '0;
        ar <= '0;
        bready <= 1'b1;
        rready <= 1'b1;
        cur_op = -1;
        where_str = "reset";
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge wr_clk);
        check_field(3, "awready", 32'(awready), 32'h0);
        check_field(3, "wready", 32'(wready), 32'h0);
        check_field(3, "arready", 32'(arready), 32'h0);
        check_field(3, "b.valid", 32'(b.valid), 32'h0);
        check_field(3, "r.valid", 32'(r.valid), 32'h0);
        rd_srst <= 1'b0;
        repeat (2) @(posedge wr_clk);
        assert (awready && wready && arready) else begin
            $display("Ready outputs did not rise in the first cycle after reset");
            err_cnt[3]++;
        end
        run_table();
        report_counts();
        if (err_cnt[0] + err_cnt[1] + err_cnt[2] + err_cnt[3] == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        #((ops.size() * OP_CYCLES + 20) * CLK_PERIOD);
        $display("Watchdog expired with table entry %0d of %0d still in progress",
                 cur_op, ops.size());
        report_counts();
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: mbox_top.sv
`timescale 1ns/1ps
module mbox_top #(
    parameter int DEPTH = 16,
    parameter mbox_pkg::opt_mode_t WR_OPT_MODE = mbox_pkg::OPT_MODE_TIMING,
    parameter mbox_pkg::opt_mode_t RD_OPT_MODE = mbox_pkg::OPT_MODE_TIMING
) (
    input  logic               wr_clk,
    input  logic               rd_srst,
    input  mbox_pkg::axil_aw_t aw,
    input  mbox_pkg::axil_w_t  w,
    input  logic               bready,
    input  mbox_pkg::axil_ar_t ar,
    input  logic               rready,
    output logic               awready,
    output logic               wready,
    output mbox_pkg::axil_b_t  b,
    output logic               arready,
    output mbox_pkg::axil_r_t  r
);
    import mbox_pkg::*;

    localparam int CNT_WID = $clog2(DEPTH + 1);

    logic               push_hi;
    logic               push_lo;
    logic [DATA_W-1:0]  push_data;
    logic               pop_hi;
    logic               pop_lo;
    logic               push_ok_hi;
    logic               push_ok_lo;
    logic               pop_ok_hi;
    logic               pop_ok_lo;
    logic               push_done_hi;
    logic               push_done_lo;
    logic               pop_done_hi;
    logic               pop_done_lo;
    logic [DATA_W-1:0]  pop_data_hi;
    logic [DATA_W-1:0]  pop_data_lo;
    logic [CNT_WID-1:0] count_hi;
    logic [CNT_WID-1:0] count_lo;
    logic               full_hi;
    logic               full_lo;
    logic               empty_hi;
    logic               empty_lo;
    buf_req_t           req_hi;
    buf_req_t           req_lo;
    buf_req_t           ram_req;
    logic               gnt_hi;
    logic               gnt_lo;
    logic               rd_valid_hi;
    logic               rd_valid_lo;
    logic [DATA_W-1:0]  rd_data;

    axil_mbox_slave #(
        .DEPTH (DEPTH)
    ) i_slave (
        .wr_clk       (wr_clk),
        .rd_srst      (rd_srst),
        .aw           (aw),
        .w            (w),
        .bready       (bready),
        .ar           (ar),
        .rready       (rready),
        .awready      (awready),
        .wready       (wready),
        .b            (b),
        .arready      (arready),
        .r            (r),
        .push_hi      (push_hi),
        .push_lo      (push_lo),
        .push_data    (push_data),
        .pop_hi       (pop_hi),
        .pop_lo       (pop_lo),
        .push_ok_hi   (push_ok_hi),
        .push_ok_lo   (push_ok_lo),
        .pop_ok_hi    (pop_ok_hi),
        .pop_ok_lo    (pop_ok_lo),
        .push_done_hi (push_done_hi),
        .push_done_lo (push_done_lo),
        .pop_done_hi  (pop_done_hi),
        .pop_done_lo  (pop_done_lo),
        .pop_data_hi  (pop_data_hi),
        .pop_data_lo  (pop_data_lo),
        .count_hi     (count_hi),
        .count_lo     (count_lo),
        .full_hi      (full_hi),
        .full_lo      (full_lo),
        .empty_hi     (empty_hi),
        .empty_lo     (empty_lo)
    );

    // High queue in the lower half of the RAM
    mbox_queue #(
        .DEPTH       (DEPTH),
        .BASE        (0),
        .WR_OPT_MODE (WR_OPT_MODE),
        .RD_OPT_MODE (RD_OPT_MODE)
    ) i_queue_hi (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .push      (push_hi),
        .push_data (push_data),
        .pop       (pop_hi),
        .req_gnt   (gnt_hi),
        .rd_valid  (rd_valid_hi),
        .rd_data   (rd_data),
        .push_ok   (push_ok_hi),
        .pop_ok    (pop_ok_hi),
        .push_done (push_done_hi),
        .pop_done  (pop_done_hi),
        .pop_data  (pop_data_hi),
        .count     (count_hi),
        .full      (full_hi),
        .empty     (empty_hi),
        .req       (req_hi)
    );

    mbox_queue #(
        .DEPTH       (DEPTH),
        .BASE        (DEPTH),
        .WR_OPT_MODE (WR_OPT_MODE),
        .RD_OPT_MODE (RD_OPT_MODE)
    ) i_queue_lo (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .push      (push_lo),
        .push_data (push_data),
        .pop       (pop_lo),
        .req_gnt   (gnt_lo),
        .rd_valid  (rd_valid_lo),
        .rd_data   (rd_data),
        .push_ok   (push_ok_lo),
        .pop_ok    (pop_ok_lo),
        .push_done (push_done_lo),
        .pop_done  (pop_done_lo),
        .pop_data  (pop_data_lo),
        .count     (count_lo),
        .full      (full_lo),
        .empty     (empty_lo),
        .req       (req_lo)
    );

    buf_arbiter i_arbiter (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .req0      (req_hi),
        .req1      (req_lo),
        .gnt0      (gnt_hi),
        .gnt1      (gnt_lo),
        .ram_req   (ram_req),
        .rd_valid0 (rd_valid_hi),
        .rd_valid1 (rd_valid_lo)
    );

    buf_ram #(
        .ENTRIES (2 * DEPTH)
    ) i_ram (
        .wr_clk  (wr_clk),
        .req     (ram_req),
        .rd_data (rd_data)
    );

endmodule

// File: axil_mbox_slave.sv
`timescale 1ns/1ps
module axil_mbox_slave #(
    parameter int DEPTH = 16
) (
    input  logic                           wr_clk,
    input  logic                           rd_srst,
    input  mbox_pkg::axil_aw_t             aw,
    input  mbox_pkg::axil_w_t              w,
    input  logic                           bready,
    input  mbox_pkg::axil_ar_t             ar,
    input  logic                           rready,
    output logic                           awready,
    output logic                           wready,
    output mbox_pkg::axil_b_t              b,
    output logic                           arready,
    output mbox_pkg::axil_r_t              r,
    output logic                           push_hi,
    output logic                           push_lo,
    output logic [mbox_pkg::DATA_W-1:0]    push_data,
    output logic                           pop_hi,
    output logic                           pop_lo,
    input  logic                           push_ok_hi,
    input  logic                           push_ok_lo,
    input  logic                           pop_ok_hi,
    input  logic                           pop_ok_lo,
    input  logic                           push_done_hi,
    input  logic                           push_done_lo,
    input  logic                           pop_done_hi,
    input  logic                           pop_done_lo,
    input  logic [mbox_pkg::DATA_W-1:0]    pop_data_hi,
    input  logic [mbox_pkg::DATA_W-1:0]    pop_data_lo,
    input  logic [$clog2(DEPTH+1)-1:0]     count_hi,
    input  logic [$clog2(DEPTH+1)-1:0]     count_lo,
    input  logic                           full_hi,
    input  logic                           full_lo,
    input  logic                           empty_hi,
    input  logic                           empty_lo
);
    import mbox_pkg::*;

    logic alive;
    logic wr_pend;
    logic wr_lo;
    logic rd_pend;
    logic rd_lo;
    logic aw_hi;
    logic aw_lo;
    logic ar_hi;
    logic ar_lo;
    logic ar_st;
    logic wr_block;
    logic rd_block;
    logic wr_fire;
    logic rd_fire;
    logic [DATA_W-1:0] status;

    // ------------------------------------------------------------------------
    // Decode and handshakes
    // ------------------------------------------------------------------------
    assign aw_hi = (aw.addr == ADDR_HI);
    assign aw_lo = (aw.addr == ADDR_LO);
    assign ar_hi = (ar.addr == ADDR_HI);
    assign ar_lo = (ar.addr == ADDR_LO);
    assign ar_st = (ar.addr == ADDR_STAT);

    // A queue serves one push or pop at a time, a new push wins
    assign wr_block = rd_pend && ((aw_hi && !rd_lo) || (aw_lo && rd_lo));
    assign rd_block = (wr_pend && ((ar_hi && !wr_lo) || (ar_lo && wr_lo)))
                    || (wr_fire && ((ar_hi && aw_hi) || (ar_lo && aw_lo)));

    assign awready = alive && !wr_pend && !b.valid && !wr_block;
    assign wready = awready;
    assign wr_fire = awready && aw.valid && w.valid;
    assign arready = alive && !rd_pend && !r.valid && !rd_block;
    assign rd_fire = arready && ar.valid;

    assign push_hi = wr_fire && aw_hi;
    assign push_lo = wr_fire && aw_lo;
    assign push_data = w.data;
    assign pop_hi = rd_fire && ar_hi;
    assign pop_lo = rd_fire && ar_lo;

    always_comb begin
        status = '0;
        status[4:0] = 5'(count_hi);
        status[12:8] = 5'(count_lo);
        status[16] = empty_hi;
        status[17] = full_hi;
        status[18] = empty_lo;
        status[19] = full_lo;
    end

    // ------------------------------------------------------------------------
    // Write response
    // ------------------------------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            alive <= 1'b0;
            wr_pend <= 1'b0;
            wr_lo <= 1'b0;
            b <= '0;
        end else begin
            alive <= 1'b1;
            if (b.valid && bready) begin
                b.valid <= 1'b0;
            end
            if (wr_fire) begin
                wr_lo <= aw_lo;
                if ((aw_hi && push_ok_hi) || (aw_lo && push_ok_lo)) begin
                    wr_pend <= 1'b1;
                end else begin
                    // Full queue, status or unmapped address
                    b <= '{resp: RESP_SLVERR, valid: 1'b1};
                end
            end
            if (wr_pend && (wr_lo ? push_done_lo : push_done_hi)) begin
                wr_pend <= 1'b0;
                b <= '{resp: RESP_OKAY, valid: 1'b1};
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read response
    // ------------------------------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            rd_pend <= 1'b0;
            rd_lo <= 1'b0;
            r <= '0;
        end else begin
            if (r.valid && rready) begin
                r.valid <= 1'b0;
            end
            if (rd_fire) begin
                rd_lo <= ar_lo;
                if (ar_st) begin
                    r <= '{data: status, resp: RESP_OKAY, valid: 1'b1};
                end else if ((ar_hi && pop_ok_hi) || (ar_lo && pop_ok_lo)) begin
                    rd_pend <= 1'b1;
                end else begin
                    r <= '{data: {DATA_W{1'b0}}, resp: RESP_SLVERR, valid: 1'b1};
                end
            end
            if (rd_pend && (rd_lo ? pop_done_lo : pop_done_hi)) begin
                rd_pend <= 1'b0;
                r <= '{data: rd_lo ? pop_data_lo : pop_data_hi, resp: RESP_OKAY,
                       valid: 1'b1};
            end
        end
    end

endmodule

// File: buf_ram.sv
`timescale 1ns/1ps
module buf_ram #(
    parameter int ENTRIES = 32
) (
    input  logic                        wr_clk,
    input  mbox_pkg::buf_req_t          req,
    output logic [mbox_pkg::DATA_W-1:0] rd_data
);
    import mbox_pkg::*;

    localparam int AW = $clog2(ENTRIES);

    logic [DATA_W-1:0] mem [ENTRIES];

    always_ff @(posedge wr_clk) begin
        if (req.valid) begin
            if (req.we) begin
                mem[req.addr[AW-1:0]] <= req.data;
            end else begin
                rd_data <= mem[req.addr[AW-1:0]];
            end
        end
    end

endmodule

// File: buf_arbiter.sv
`timescale 1ns/1ps
module buf_arbiter (
    input  logic               wr_clk,
    input  logic               rd_srst,
    input  mbox_pkg::buf_req_t req0,
    input  mbox_pkg::buf_req_t req1,
    output logic               gnt0,
    output logic               gnt1,
    output mbox_pkg::buf_req_t ram_req,
    output logic               rd_valid0,
    output logic               rd_valid1
);
    // Set when queue 1 has priority
    logic rr;

    assign gnt0 = req0.valid && (!req1.valid || !rr);
    assign gnt1 = req1.valid && (!req0.valid || rr);

    // Idle cycles forward req0 with valid low
    assign ram_req = gnt1 ? req1 : req0;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            rr <= 1'b0;
        end else if (gnt0) begin
            rr <= 1'b1;
        end else if (gnt1) begin
            rr <= 1'b0;
        end
    end

    // Read data comes back one cycle after the grant
    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            rd_valid0 <= 1'b0;
            rd_valid1 <= 1'b0;
        end else begin
            rd_valid0 <= gnt0 && !req0.we;
            rd_valid1 <= gnt1 && !req1.we;
        end
    end

endmodule

// File: mbox_queue.sv
`timescale 1ns/1ps
module mbox_queue #(
    parameter int DEPTH = 16,
    parameter int BASE = 0,
    parameter mbox_pkg::opt_mode_t WR_OPT_MODE = mbox_pkg::OPT_MODE_TIMING,
    parameter mbox_pkg::opt_mode_t RD_OPT_MODE = mbox_pkg::OPT_MODE_TIMING
) (
    input  logic                           wr_clk,
    input  logic                           rd_srst,
    input  logic                           push,
    input  logic [mbox_pkg::DATA_W-1:0]    push_data,
    input  logic                           pop,
    input  logic                           req_gnt,
    input  logic                           rd_valid,
    input  logic [mbox_pkg::DATA_W-1:0]    rd_data,
    output logic                           push_ok,
    output logic                           pop_ok,
    output logic                           push_done,
    output logic                           pop_done,
    output logic [mbox_pkg::DATA_W-1:0]    pop_data,
    output logic [$clog2(DEPTH+1)-1:0]     count,
    output logic                           full,
    output logic                           empty,
    output mbox_pkg::buf_req_t             req
);
    import mbox_pkg::*;

    localparam int PTR_WID = DEPTH > 1 ? $clog2(DEPTH) : 1;

    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;

    // One-entry request slot
    logic              slot_vld;
    logic              slot_we;
    logic [BUF_AW-1:0] slot_addr;
    logic [DATA_W-1:0] slot_data;

    fifo_ctrl_fsm #(
        .DEPTH       (DEPTH),
        .OFLOW_PROT  (1'b1),
        .UFLOW_PROT  (1'b1),
        .WR_OPT_MODE (WR_OPT_MODE),
        .RD_OPT_MODE (RD_OPT_MODE)
    ) i_ctrl (
        .wr_clk   (wr_clk),
        .rd_srst  (rd_srst),
        .wr       (push),
        // Push wins when both arrive together
        .rd       (pop && !push),
        .mem_rdy  (!slot_vld),
        .wr_rdy   (),
        .wr_safe  (push_ok),
        .wr_ptr   (wr_ptr),
        .wr_count (count),
        .wr_full  (full),
        .wr_oflow (),
        .rd_safe  (pop_ok),
        .rd_ptr   (rd_ptr),
        .rd_count (),
        .rd_empty (empty),
        .rd_uflow ()
    );

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            slot_vld <= 1'b0;
        end else if (push_ok || pop_ok) begin
            slot_vld <= 1'b1;
        end else if (req_gnt) begin
            slot_vld <= 1'b0;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push_ok) begin
            slot_we <= 1'b1;
            slot_addr <= BUF_AW'(BASE) + BUF_AW'(wr_ptr);
            slot_data <= push_data;
        end else if (pop_ok) begin
            slot_we <= 1'b0;
            slot_addr <= BUF_AW'(BASE) + BUF_AW'(rd_ptr);
        end
    end

    assign req = '{valid: slot_vld, we: slot_we, addr: slot_addr, data: slot_data};

    assign push_done = slot_vld && slot_we && req_gnt;
    assign pop_done = rd_valid;
    assign pop_data = rd_data;

endmodule

// File: fifo_ctrl_fsm.sv
`timescale 1ns/1ps
module fifo_ctrl_fsm #(
    parameter int DEPTH = 16,
    parameter bit OFLOW_PROT = 1,
    parameter bit UFLOW_PROT = 1,
    parameter mbox_pkg::opt_mode_t WR_OPT_MODE = mbox_pkg::OPT_MODE_TIMING,
    parameter mbox_pkg::opt_mode_t RD_OPT_MODE = mbox_pkg::OPT_MODE_TIMING,
    localparam int PTR_WID = DEPTH > 1 ? $clog2(DEPTH) : 1,
    localparam int CNT_WID = $clog2(DEPTH + 1)
) (
    input  logic               wr_clk,
    input  logic               rd_srst,
    input  logic               wr,
    input  logic               rd,
    input  logic               mem_rdy,
    output logic               wr_rdy,
    output logic               wr_safe,
    output logic [PTR_WID-1:0] wr_ptr,
    output logic [CNT_WID-1:0] wr_count,
    output logic               wr_full,
    output logic               wr_oflow,
    output logic               rd_safe,
    output logic [PTR_WID-1:0] rd_ptr,
    output logic [CNT_WID-1:0] rd_count,
    output logic               rd_empty,
    output logic               rd_uflow
);
    import mbox_pkg::*;

    // Pointers carry one extra bit so that full and empty differ
    logic [CNT_WID-1:0] wr_ptr_q;
    logic [CNT_WID-1:0] rd_ptr_q;
    logic [CNT_WID-1:0] occ;

    // ------------------------------------------------------------------------
    // Pointers
    // ------------------------------------------------------------------------
    assign wr_safe = OFLOW_PROT ? (wr && wr_rdy) : wr;
    assign rd_safe = UFLOW_PROT ? (rd && !rd_empty) : rd;
    assign wr_oflow = wr && !wr_rdy;
    assign rd_uflow = rd && rd_empty;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (wr_safe) begin
                wr_ptr_q <= wr_ptr_q + CNT_WID'(1);
            end
            if (rd_safe) begin
                rd_ptr_q <= rd_ptr_q + CNT_WID'(1);
            end
        end
    end

    assign wr_ptr = wr_ptr_q[PTR_WID-1:0];
    assign rd_ptr = rd_ptr_q[PTR_WID-1:0];
    assign occ = wr_ptr_q - rd_ptr_q;

    // ------------------------------------------------------------------------
    // Counts and flags
    // ------------------------------------------------------------------------
    generate
        if (WR_OPT_MODE == OPT_MODE_TIMING) begin : g_wr_timing
            // Writes seen at once, reads one cycle late
            always_ff @(posedge wr_clk) begin
                if (rd_srst) begin
                    wr_count <= '0;
                    wr_full <= 1'b0;
                    wr_rdy <= 1'b0;
                end else if (wr_safe) begin
                    wr_count <= occ + CNT_WID'(1);
                    wr_full <= (occ >= CNT_WID'(DEPTH - 1));
                    wr_rdy <= mem_rdy && (occ < CNT_WID'(DEPTH - 1));
                end else begin
                    wr_count <= occ;
                    wr_full <= (occ == CNT_WID'(DEPTH));
                    wr_rdy <= mem_rdy && (occ < CNT_WID'(DEPTH));
                end
            end
        end else begin : g_wr_latency
            assign wr_count = occ;
            assign wr_full = (occ == CNT_WID'(DEPTH));
            assign wr_rdy = mem_rdy && (occ < CNT_WID'(DEPTH));
        end

        if (RD_OPT_MODE == OPT_MODE_TIMING) begin : g_rd_timing
            // Reads seen at once, writes one cycle late
            always_ff @(posedge wr_clk) begin
                if (rd_srst) begin
                    rd_count <= '0;
                    rd_empty <= 1'b1;
                end else if (rd_safe) begin
                    rd_count <= occ - CNT_WID'(1);
                    rd_empty <= (occ <= CNT_WID'(1));
                end else begin
                    rd_count <= occ;
                    rd_empty <= (occ == '0);
                end
            end
        end else begin : g_rd_latency
            assign rd_count = occ;
            assign rd_empty = (occ == '0);
        end
    endgenerate

endmodule

// File: mbox_pkg.sv
package mbox_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int DATA_W = 32;
    localparam int AXIL_AW = 4;
    // Wide enough for a RAM of up to 256 entries
    localparam int BUF_AW = 8;

    // Registered or combinational counts and flags
    typedef enum logic {
        OPT_MODE_TIMING,
        OPT_MODE_LATENCY
    } opt_mode_t;

    // ------------------------------------------------------------------------
    // AXI4-Lite channels
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [AXIL_AW-1:0] addr;
        logic               valid;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              valid;
    } axil_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        logic [AXIL_AW-1:0] addr;
        logic               valid;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              valid;
    } axil_r_t;

    // Buffer RAM request, queue to arbiter and arbiter to RAM
    typedef struct packed {
        logic              valid;
        logic              we;
        logic [BUF_AW-1:0] addr;
        logic [DATA_W-1:0] data;
    } buf_req_t;

    // Register map
    localparam logic [AXIL_AW-1:0] ADDR_HI = 4'h0;
    localparam logic [AXIL_AW-1:0] ADDR_LO = 4'h4;
    localparam logic [AXIL_AW-1:0] ADDR_STAT = 4'h8;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
